/* exu_pkg.sv */
`default_nettype none

package exu_pkg;

    // rv32m operations, encoded as the funct3 field
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REM_U  = 3'd7
    } muldiv_op_e;

    // default widths, handed down by the top level
    localparam int XLEN_DEF       = 32;
    localparam int REG_ADDR_W_DEF = 5;

    // multiplier latency from start to valid
    localparam int MUL_STAGES = 2;

    // divide and remainder share the iterative engine
    function automatic logic op_is_div(input muldiv_op_e op);
        return op inside {DIV, DIVU, REM, REM_U};
    endfunction

    // remainder selects the partial remainder instead of the quotient
    function automatic logic op_is_rem(input muldiv_op_e op);
        return (op == REM) || (op == REM_U);
    endfunction

endpackage

`default_nettype wire

/* exu_muldiv_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_muldiv_issue #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      req_i,
    input  wire exu_pkg::muldiv_op_e op_i,
    input  wire [XLEN-1:0]           rs1_i,
    input  wire [XLEN-1:0]           rs2_i,
    input  wire [REG_ADDR_W-1:0]     rd_i,
    input  wire                      int_assert_i,
    input  wire                      done_i,
    output logic                     hold_flag_o,
    output logic                     started_o,
    output logic                     mul_start_o,
    output logic                     div_start_o,
    output exu_pkg::muldiv_op_e      op_o,
    output logic [XLEN-1:0]          op_a_o,
    output logic [XLEN-1:0]          op_b_o,
    output logic [REG_ADDR_W-1:0]    rd_o,
    output logic                     kill_o
);

    logic busy_q;
    logic mul_start_q;
    logic div_start_q;
    logic accept;
    logic req_div;

    // new work only when idle and no interrupt pending
    assign accept  = req_i && !busy_q && !int_assert_i;
    assign req_div = exu_pkg::op_is_div(op_i);

    // interrupt cancels whatever is in flight
    assign kill_o = busy_q && int_assert_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= accept && !req_div;
            div_start_q <= accept && req_div;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i || kill_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operands stay stable for the engines until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o   <= op_i;
            op_a_o <= rs1_i;
            op_b_o <= rs2_i;
            rd_o   <= rd_i;
        end
    end

    assign hold_flag_o = busy_q;
    assign mul_start_o = mul_start_q;
    assign div_start_o = div_start_q;
    // start report for the interrupt controller
    assign started_o   = mul_start_q | div_start_q;

    // requester must wait out the hold
    a_no_req_in_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i |-> !hold_flag_o);

    // each acceptance gives one single-cycle start to one engine
    a_one_start: assert property (@(posedge clk) disable iff (!arst_n_i)
        accept |=> $onehot({mul_start_o, div_start_o}) ##1 !(mul_start_o || div_start_o));

    // every writeback traces back to a start at the fixed engine latency
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_i |-> ($past(mul_start_o, exu_pkg::MUL_STAGES + 1)
                    || $past(div_start_o, XLEN + 2)));

endmodule

`default_nettype wire

/* exu_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_mul #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      start_i,
    input  wire exu_pkg::muldiv_op_e op_i,
    input  wire [XLEN-1:0]           a_i,
    input  wire [XLEN-1:0]           b_i,
    input  wire                      kill_i,
    output logic                     valid_o,
    output logic [XLEN-1:0]          result_o
);

    localparam int STAGES = exu_pkg::MUL_STAGES;
    // full product of two XLEN+1 bit operands
    localparam int PW     = 2 * XLEN + 2;

    logic [STAGES-1:0]      vld_q;
    logic                   a_sgn;
    logic                   b_sgn;
    logic signed [XLEN:0]   a_ext;
    logic signed [XLEN:0]   b_ext;
    logic signed [PW-1:0]   prod_q;
    logic                   hi_q;
    logic [XLEN-1:0]        result_q;

    // mulh treats both signed, mulhsu only rs1, mulhu neither
    assign a_sgn = (op_i == exu_pkg::MULH) || (op_i == exu_pkg::MULHSU);
    assign b_sgn = (op_i == exu_pkg::MULH);
    assign a_ext = {a_sgn & a_i[XLEN-1], a_i};
    assign b_ext = {b_sgn & b_i[XLEN-1], b_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (kill_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[STAGES-2:0], start_i};
        end
    end

    // stage 1 multiplies and the last stage picks the word
    always_ff @(posedge clk) begin
        if (start_i) begin
            prod_q <= PW'(a_ext) * PW'(b_ext);
            hi_q   <= (op_i != exu_pkg::MUL);
        end
        if (vld_q[STAGES-2]) begin
            result_q <= hi_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
        end
    end

    assign valid_o  = vld_q[STAGES-1];
    assign result_o = result_q;

endmodule

`default_nettype wire

/* exu_div.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_div #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      start_i,
    input  wire exu_pkg::muldiv_op_e op_i,
    input  wire [XLEN-1:0]           a_i,
    input  wire [XLEN-1:0]           b_i,
    input  wire                      kill_i,
    output logic                     valid_o,
    output logic [XLEN-1:0]          result_o
);

    localparam int CNT_W = $clog2(XLEN);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             valid_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  dvs_q;
    logic             rem_sel_q;
    logic             neg_q_q;
    logic             neg_r_q;
    logic             zero_q;
    logic [XLEN-1:0]  result_q;

    logic             is_signed;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    diff;
    logic             q_bit;
    logic [XLEN-1:0]  rem_next;
    logic [XLEN-1:0]  quo_next;
    logic [XLEN-1:0]  quo_fix;
    logic [XLEN-1:0]  rem_fix;
    logic             last;

    assign is_signed = (op_i == exu_pkg::DIV) || (op_i == exu_pkg::REM);
    assign a_mag = (is_signed && a_i[XLEN-1]) ? -a_i : a_i;
    assign b_mag = (is_signed && b_i[XLEN-1]) ? -b_i : b_i;

    // one restoring step as dividend bits shift out of the quotient register
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs_q};
    assign q_bit     = !diff[XLEN];
    assign rem_next  = q_bit ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
    assign quo_next  = {quo_q[XLEN-2:0], q_bit};
    assign last      = (cnt_q == CNT_W'(XLEN - 1));

    // x/0 gives all ones; min/-1 already falls out of the magnitudes
    assign quo_fix = zero_q ? '1 : (neg_q_q ? -quo_next : quo_next);
    // remainder takes the dividend sign, so x%0 returns x
    assign rem_fix = neg_r_q ? -rem_next : rem_next;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (kill_i) begin
                busy_q <= 1'b0;
            end else if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvs_q     <= b_mag;
            rem_sel_q <= exu_pkg::op_is_rem(op_i);
            neg_q_q   <= is_signed && (a_i[XLEN-1] ^ b_i[XLEN-1]);
            neg_r_q   <= is_signed && a_i[XLEN-1];
            zero_q    <= (b_i == '0);
        end else if (busy_q) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
            if (last) begin
                result_q <= rem_sel_q ? rem_fix : quo_fix;
            end
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

    // issue holds the pipeline, so no second start during an iteration
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy_q);

endmodule

`default_nettype wire

/* exu_muldiv_wb.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_muldiv_wb #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   mul_valid_i,
    input  wire [XLEN-1:0]        mul_result_i,
    input  wire                   div_valid_i,
    input  wire [XLEN-1:0]        div_result_i,
    input  wire [REG_ADDR_W-1:0]  rd_i,
    input  wire                   kill_i,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o,
    output logic [XLEN-1:0]       reg_wdata_o,
    output logic                  done_o
);

    logic                  we_q;
    logic [REG_ADDR_W-1:0] waddr_q;
    logic [XLEN-1:0]       wdata_q;
    logic                  any_valid;

    assign any_valid = mul_valid_i || div_valid_i;

    // a completion that meets an interrupt is dropped here
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_q <= 1'b0;
        end else begin
            we_q <= any_valid && !kill_i;
        end
    end

    always_ff @(posedge clk) begin
        if (any_valid) begin
            wdata_q <= div_valid_i ? div_result_i : mul_result_i;
            waddr_q <= rd_i;
        end
    end

    assign reg_we_o    = we_q;
    assign reg_waddr_o = waddr_q;
    assign reg_wdata_o = wdata_q;
    // done tells issue to release hold
    assign done_o      = we_q;

    // only one engine runs at a time
    a_one_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mul_valid_i && div_valid_i));

endmodule

`default_nettype wire

/* exu_muldiv.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_muldiv #(
    parameter int XLEN       = exu_pkg::XLEN_DEF,
    parameter int REG_ADDR_W = exu_pkg::REG_ADDR_W_DEF
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      req_i,
    input  wire exu_pkg::muldiv_op_e op_i,
    input  wire [XLEN-1:0]           rs1_i,
    input  wire [XLEN-1:0]           rs2_i,
    input  wire [REG_ADDR_W-1:0]     rd_i,
    input  wire                      int_assert_i,
    output wire                      hold_flag_o,
    output wire                      muldiv_started_o,
    output wire                      reg_we_o,
    output wire [REG_ADDR_W-1:0]     reg_waddr_o,
    output wire [XLEN-1:0]           reg_wdata_o
);

    // issue to engines
    wire                      mul_start;
    wire                      div_start;
    wire exu_pkg::muldiv_op_e op;
    wire [XLEN-1:0]           op_a;
    wire [XLEN-1:0]           op_b;
    wire                      kill;
    // engines to writeback
    wire                      mul_valid;
    wire [XLEN-1:0]           mul_result;
    wire                      div_valid;
    wire [XLEN-1:0]           div_result;
    // issue and writeback
    wire [REG_ADDR_W-1:0]     rd;
    wire                      done;

    exu_muldiv_issue #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_issue (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .rd_i         (rd_i),
        .int_assert_i (int_assert_i),
        .done_i       (done),
        .hold_flag_o  (hold_flag_o),
        .started_o    (muldiv_started_o),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start),
        .op_o         (op),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .rd_o         (rd),
        .kill_o       (kill)
    );

    exu_mul #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_mul (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mul_start),
        .op_i     (op),
        .a_i      (op_a),
        .b_i      (op_b),
        .kill_i   (kill),
        .valid_o  (mul_valid),
        .result_o (mul_result)
    );

    exu_div #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_div (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (div_start),
        .op_i     (op),
        .a_i      (op_a),
        .b_i      (op_b),
        .kill_i   (kill),
        .valid_o  (div_valid),
        .result_o (div_result)
    );

    exu_muldiv_wb #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_wb (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mul_valid_i  (mul_valid),
        .mul_result_i (mul_result),
        .div_valid_i  (div_valid),
        .div_result_i (div_result),
        .rd_i         (rd),
        .kill_i       (kill),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .done_o       (done)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF = PERIOD_NS / 2;

    initial begin
        clk_o = 1'b0;
        forever #(HALF) clk_o = ~clk_o;
    end

    initial begin
        // short high phase gives the flops a real falling reset edge
        arst_n_o = 1'b1;
        #(PERIOD_NS / 4);
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // release lands between edges, clear of both clock phases
        #(PERIOD_NS / 4);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  wire                      clk_i,
    input  wire                      arst_n_i,
    input  wire                      req_i,
    input  wire exu_pkg::muldiv_op_e op_i,
    input  wire                      int_assert_i,
    input  wire [REG_ADDR_W-1:0]     exp_rd_i,
    input  wire [XLEN-1:0]           exp_data_i,
    input  wire                      exp_cancel_i,
    input  wire                      hold_flag_i,
    input  wire                      started_i,
    input  wire                      reg_we_i,
    input  wire [REG_ADDR_W-1:0]     reg_waddr_i,
    input  wire [XLEN-1:0]           reg_wdata_i,
    output int                       err_count_o,
    output int                       writes_o
);

    // cycles since the accepting cycle or 0 while idle
    int                    age = 0;
    // last cycle in which hold is expected high
    int                    last_q = 0;
    int                    errors = 0;
    int                    writes = 0;
    logic                  cancel_q = 1'b0;
    logic [REG_ADDR_W-1:0] rd_q = '0;
    logic [XLEN-1:0]       data_q = '0;

    assign err_count_o = errors;
    assign writes_o    = writes;

    // divide and remainder take the iterative path
    function automatic int latency(input exu_pkg::muldiv_op_e op);
        if (op == exu_pkg::DIV || op == exu_pkg::DIVU || op == exu_pkg::REM
            || op == exu_pkg::REM_U) begin
            return XLEN + 3;
        end
        return 4;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    // sampled on the rising edge since inputs settle at the falling edge
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            check_bit("hold_flag_o", 1'b0, hold_flag_i);
            check_bit("muldiv_started_o", 1'b0, started_i);
            check_bit("reg_we_o", 1'b0, reg_we_i);
            age <= 0;
        end else begin
            // every write pulse the DUT makes is counted
            if (reg_we_i) begin
                writes = writes + 1;
            end
            check_bit("muldiv_started_o", age == 1, started_i);
            if (age == 0 || age > last_q) begin
                check_bit("hold_flag_o", 1'b0, hold_flag_i);
                check_bit("reg_we_o", 1'b0, reg_we_i);
                if (req_i && !int_assert_i) begin
                    age      <= 1;
                    cancel_q <= exp_cancel_i;
                    rd_q     <= exp_rd_i;
                    data_q   <= exp_data_i;
                    // a cancelled op is killed in its second busy cycle
                    last_q   <= exp_cancel_i ? 2 : latency(op_i);
                end else begin
                    age <= 0;
                end
            end else begin
                check_bit("hold_flag_o", 1'b1, hold_flag_i);
                check_bit("reg_we_o", !cancel_q && age == last_q, reg_we_i);
                if (!cancel_q && age == last_q) begin
                    check_word("reg_waddr_o", XLEN'(rd_q), XLEN'(reg_waddr_i));
                    check_word("reg_wdata_o", data_q, reg_wdata_i);
                end
                age <= age + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_exu_muldiv.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_exu_muldiv;

    localparam int XLEN        = exu_pkg::XLEN_DEF;
    localparam int REG_ADDR_W  = exu_pkg::REG_ADDR_W_DEF;
    localparam int TIMEOUT     = XLEN + 10;
    localparam int SEL_STARTED = 0;
    localparam int SEL_WE      = 1;
    localparam int SEL_HOLD    = 2;

    logic                  clk;
    logic                  arst_n;
    logic                  req;
    exu_pkg::muldiv_op_e   op;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  int_assert;
    wire                   hold_flag;
    wire                   started;
    wire                   reg_we;
    wire [REG_ADDR_W-1:0]  reg_waddr;
    wire [XLEN-1:0]        reg_wdata;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_data;
    logic                  exp_cancel;
    int                    check_errors;
    int                    writes;
    int                    run_errors;
    int                    expected_writes;
    int                    cases_run;
    logic [15:0]           lfsr;

    tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    exu_muldiv #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) exu_muldiv_i (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .req_i            (req),
        .op_i             (op),
        .rs1_i            (rs1),
        .rs2_i            (rs2),
        .rd_i             (rd),
        .int_assert_i     (int_assert),
        .hold_flag_o      (hold_flag),
        .muldiv_started_o (started),
        .reg_we_o         (reg_we),
        .reg_waddr_o      (reg_waddr),
        .reg_wdata_o      (reg_wdata)
    );

    tb_checker #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_checker (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_i        (req),
        .op_i         (op),
        .int_assert_i (int_assert),
        .exp_rd_i     (exp_rd),
        .exp_data_i   (exp_data),
        .exp_cancel_i (exp_cancel),
        .hold_flag_i  (hold_flag),
        .started_i    (started),
        .reg_we_i     (reg_we),
        .reg_waddr_i  (reg_waddr),
        .reg_wdata_i  (reg_wdata),
        .err_count_o  (check_errors),
        .writes_o     (writes)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_gap(output logic [2:0] gap);
        gap = 3'd0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = {gap[1:0], lfsr[0]};
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SEL_STARTED: return started;
            SEL_WE:      return reg_we;
            default:     return hold_flag;
        endcase
    endfunction

    // outputs are read at the falling edge, half a cycle after they change
    task automatic wait_level(input int sel, input logic level, input string name);
        int n;
        n = 0;
        while (probe(sel) !== level && n < TIMEOUT) begin
            @(negedge clk);
            n = n + 1;
        end
        if (probe(sel) !== level) begin
            $display("timeout: %s did not reach %0b within %0d cycles", name, level, TIMEOUT);
            run_errors = run_errors + 1;
        end
    endtask

    task automatic run_case(input logic [31:0] f_op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] dst,
                            input logic [XLEN-1:0] expect_val, input logic cancel);
        op         = exu_pkg::muldiv_op_e'(f_op[2:0]);
        rs1        = a;
        rs2        = b;
        rd         = dst;
        exp_rd     = dst;
        exp_data   = expect_val;
        exp_cancel = cancel;
        req        = 1'b1;
        @(negedge clk);
        req = 1'b0;
        wait_level(SEL_STARTED, 1'b1, "muldiv_started_o");
        if (cancel) begin
            // interrupt two cycles after the accepting cycle, one cycle wide
            @(negedge clk);
            int_assert = 1'b1;
            @(negedge clk);
            int_assert = 1'b0;
        end else begin
            wait_level(SEL_WE, 1'b1, "reg_we_o");
        end
        wait_level(SEL_HOLD, 1'b0, "hold_flag_o");
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_rd;
        logic [31:0] f_exp;
        logic [31:0] f_cancel;
        logic [2:0]  gap;
        req             = 1'b0;
        op              = exu_pkg::MUL;
        rs1             = '0;
        rs2             = '0;
        rd              = '0;
        int_assert      = 1'b0;
        exp_rd          = '0;
        exp_data        = '0;
        exp_cancel      = 1'b0;
        run_errors      = 0;
        expected_writes = 0;
        cases_run       = 0;
        lfsr            = 16'd33;
        n = 0;
        while (arst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n = n + 1;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            run_errors = run_errors + 1;
        end
        @(negedge clk);
        fd = $fopen("muldiv_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open muldiv_cases.txt");
            run_errors = run_errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comments and blank lines
                if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f_op, f_rs1, f_rs2, f_rd, f_exp, f_cancel);
                    if (n != 6) begin
                        $display("malformed case line: %s", line);
                        run_errors = run_errors + 1;
                    end else begin
                        run_case(f_op, f_rs1, f_rs2, f_rd[REG_ADDR_W-1:0], f_exp,
                                 f_cancel[0]);
                        cases_run = cases_run + 1;
                        if (!f_cancel[0]) begin
                            expected_writes = expected_writes + 1;
                        end
                        next_gap(gap);
                        repeat (gap) @(negedge clk);
                    end
                end
            end
            $fclose(fd);
        end
        // let any stray write show up before closing
        repeat (4) @(negedge clk);
        if (cases_run == 0) begin
            $display("no cases were run");
            run_errors = run_errors + 1;
        end
        if (writes != expected_writes) begin
            $display("saw %0d register writes but expected %0d", writes, expected_writes);
            run_errors = run_errors + 1;
        end
        $display("errors: %0d compare, %0d run", check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* muldiv_cases.txt */
# op rs1 rs2 rd expected cancel, all hex
# op is funct3: 0 mul 1 mulh 2 mulhsu 3 mulhu 4 div 5 divu 6 rem 7 remu
0 00000007 00000006 01 0000002a 0
0 fffffffd fffffffb 02 0000000f 0
0 ffffffff ffffffff 03 00000001 0
1 80000000 80000000 04 40000000 0
1 fffffffd 00000005 05 ffffffff 0
2 ffffffff ffffffff 06 ffffffff 0
2 00000002 80000000 07 00000001 0
3 ffffffff ffffffff 08 fffffffe 0
0 00001234 00000010 09 00000000 1
3 00010000 00010000 0a 00000001 0
4 ffffffec 00000003 0b fffffffa 0
4 00000007 fffffffd 0c fffffffe 0
4 00000005 00000000 0d ffffffff 0
4 80000000 ffffffff 0e 80000000 0
5 ffffffff 00000010 0f 0fffffff 0
6 ffffffec 00000003 10 fffffffe 0
6 80000000 ffffffff 11 00000000 0
6 fffffff9 00000000 12 fffffff9 0
5 00000064 00000007 13 00000000 1
7 00000064 00000007 14 00000002 0

/* all.f */
exu_pkg.sv
exu_muldiv_issue.sv
exu_mul.sv
exu_div.sv
exu_muldiv_wb.sv
exu_muldiv.sv
tb_clk_gen.sv
tb_checker.sv
tb_exu_muldiv.sv

/* Makefile */
TOP := tb_exu_muldiv

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps \
		--top-module exu_muldiv -f all.f

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f all.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
